// File: list.f
logic/ld_pkg.sv
logic/ld_pipe_slice.sv
logic/ld_admit.sv
logic/ld_bit_buffer.sv
logic/ld_lane_decode.sv
logic/ld_top.sv
verif/ld_clk_gen.sv
verif/ld_tb.sv

// File: Makefile
# Verilator build and run for the lane pre-decoder testbench.
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= ld_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN  = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, whatever the simulator returns.
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/ld_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the lane pre-decoder.
// Stimulus table with LCG windows, a reference model of the admit,
// buffer and lane rules, compare tasks and a cycle limit.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ld_tb;
   import ld_pkg::*;

   localparam int win_words   = window_bits / 32;
   // words that fit before the write index runs into a read index of 0.
   localparam int stall_words = buf_words - win_words + 1;

   typedef struct packed {
      window_t    window;
      numbits_t   numbits;
      logic       sob;
      logic       eob;
      logic       credit;
      logic       sp_follow;
      buf_idx_t   sp_buf_idx;
      logic [7:0] ready_pat;
      logic       wait_stall;
   } entry_t;

   logic     clk;
   logic     rst_n;
   logic     in_valid;
   logic     in_ready;
   ld_meta_t in_word;
   logic     sob_credit_avail;
   logic     sob_credit_used;
   logic     eob_credit_used;
   logic     out_valid;
   logic     out_ready;
   ld_word_t out_word;
   buf_idx_t sp_buf_idx;
   bit_buf_t bit_buf;
   logic     buf_full_stall;

   entry_t      table_q[$];
   ld_word_t    exp_q[$];
   int          acc_q[$];
   window_t     win_hist[$];
   int unsigned lcg_state = 99723;
   int          cyc = 0;
   int          n_acc = 0;
   int          n_received = 0;
   int          ready_run = 0;
   int          quiet_run = 0;
   int          sob_words = 0;
   int          eob_words = 0;
   int          sob_pulses = 0;
   int          eob_pulses = 0;
   word_pos_t   pos_m = '0;
   logic [7:0]  rdy_pat = 8'hff;
   logic        sp_follow = 1'b0;
   buf_idx_t    sp_hold = '0;

   ld_clk_gen #(.reset_cycles(4)) clk_gen_i (.clk, .rst_n);

   ld_top #(.buf_words(buf_words)) dut_i (
      .clk, .rst_n, .in_valid, .in_word, .in_ready,
      .sob_credit_avail, .sob_credit_used, .eob_credit_used,
      .out_valid, .out_ready, .out_word, .sp_buf_idx, .bit_buf, .buf_full_stall
   );

   task automatic fail_now(string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_meta(string name, ld_meta_t exp, ld_meta_t act);
      if (act !== exp) begin
         fail_now($sformatf("CHECK FAILED %s: expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic check_lane(string name, ld_lane_t exp, ld_lane_t act);
      if (act !== exp) begin
         fail_now($sformatf("CHECK FAILED %s: expected %h actual %h", name, exp, act));
      end
   endtask

   task automatic check_pulse(string name, logic exp, logic act);
      if (act !== exp) begin
         fail_now($sformatf("CHECK FAILED %s: expected %b actual %b", name, exp, act));
      end
   endtask

   task automatic check_count(string name, int exp, int act);
      if (act != exp) begin
         fail_now($sformatf("CHECK FAILED %s: expected %0d actual %0d", name, exp, act));
      end
   endtask

   task automatic check_bit_buf(string name, bit_buf_t exp, bit_buf_t act);
      for (int k = 0; k < buf_words; k++) begin
         if (act[k] !== exp[k]) begin
            fail_now($sformatf("CHECK FAILED %s word %0d: expected %h actual %h",
                               name, k, exp[k], act[k]));
         end
      end
   endtask

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic logic [7:0] random_pattern();
      logic [31:0] r;
      r = lcg_next();
      return r[15:8] | 8'h21;
   endfunction

   function automatic numbits_t pick_numbits(int k);
      case (k % 3)
         0:       return 8'd32;
         1:       return 8'd20;
         default: return 8'd40;
      endcase
   endfunction

   task automatic add_entry(numbits_t nb, logic sob, logic eob, logic credit,
                            logic follow, buf_idx_t hold, logic [7:0] pat, logic stall);
      entry_t e;
      e.window     = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
      e.numbits    = nb;
      e.sob        = sob;
      e.eob        = eob;
      e.credit     = credit;
      e.sp_follow  = follow;
      e.sp_buf_idx = hold;
      e.ready_pat  = pat;
      e.wait_stall = stall;
      sob_words    = sob_words + int'(sob);
      eob_words    = eob_words + int'(eob);
      table_q.push_back(e);
   endtask

   task automatic build_table();
      // block longer than 8 words, read index held at 0 until the buffer fills.
      for (int k = 0; k < 15; k++) begin
         add_entry(pick_numbits(k), k == 0, k == 14, 1'b1, k == 14, '0, 8'hff, k == 14);
      end
      // new block waits for its credit; the other words need none.
      for (int k = 0; k < 4; k++) begin
         add_entry(pick_numbits(k + 1), k == 0, k == 3, 1'b0, 1'b1, '0, random_pattern(), 1'b0);
      end
      for (int k = 0; k < 10; k++) begin
         add_entry(pick_numbits(k), k == 0, k == 9, 1'b1, 1'b1, '0, 8'hff, 1'b0);
      end
      add_entry(8'd20, 1'b1, 1'b1, 1'b1, 1'b1, '0, 8'hff, 1'b0);
      for (int k = 0; k < 8; k++) begin
         add_entry(pick_numbits(k), k == 0, k == 7, 1'b1, 1'b1, '0, random_pattern(), 1'b0);
      end
   endtask

   // each lane takes 8 bits from bit i and a block end rounds up to a word edge.
   function automatic ld_word_t expect_word(ld_meta_t m, word_pos_t pos, buf_idx_t idx);
      ld_word_t w;
      int       last;
      int       e;
      w               = '0;
      w.meta          = m;
      w.meta.word_pos = pos;
      w.meta.buf_idx  = idx;
      for (int i = 0; i < n_lanes; i++) begin
         last                = i + 8;
         w.lanes[i].symbol   = m.window[i +: 8];
         w.lanes[i].error    = last > int'(m.numbits);
         w.lanes[i].errcode  = w.lanes[i].error ? end_mismatch : none;
         w.lanes[i].eob      = w.lanes[i].error || (last == int'(m.numbits) && m.eob);
         e = int'(pos) * 32 + last;
         if (w.lanes[i].eob && (e % 32) != 0) begin
            e = e + 32 - (e % 32);
         end
         w.lanes[i].end_idx = end_idx_t'(e % 256);
      end
      return w;
   endfunction

   // word k lands at index k, so every slot is written once 13 words are in.
   function automatic bit_buf_t model_buf(int n);
      bit_buf_t b;
      b = '0;
      for (int k = 0; k < n; k++) begin
         for (int w = 0; w < win_words; w++) begin
            b[(k + w) % buf_words] = win_hist[k][32*w +: 32];
         end
      end
      return b;
   endfunction

   task automatic record_accept();
      word_pos_t pos;
      pos   = in_word.sob ? word_pos_t'(0) : pos_m;
      pos_m = pos + 3'd1;
      // write index is the word count modulo twice the buffer size.
      exp_q.push_back(expect_word(in_word, pos, buf_idx_t'(n_acc)));
      acc_q.push_back(cyc);
      win_hist.push_back(in_word.window);
      n_acc++;
   endtask

   task automatic take_output();
      ld_word_t exp;
      int       lat;
      if (exp_q.size() == 0) begin
         fail_now("an output word arrived with no accepted word pending");
      end else begin
         exp = exp_q.pop_front();
         lat = cyc - acc_q.pop_front();
         // only words that saw neither back-pressure nor a stall.
         if (ready_run > lat && quiet_run > lat) begin
            check_count($sformatf("latency of word %0d", n_received), 3, lat);
         end
         check_meta($sformatf("word %0d meta", n_received), exp.meta, out_word.meta);
         for (int i = 0; i < n_lanes; i++) begin
            check_lane($sformatf("word %0d lane %0d", n_received, i),
                       exp.lanes[i], out_word.lanes[i]);
         end
         n_received++;
      end
   endtask

   // transfers are judged at the falling edge, ahead of the edge that takes them.
   always @(negedge clk) begin
      if (rst_n) begin
         check_pulse("sob_credit_used", in_valid && in_ready && in_word.sob, sob_credit_used);
         check_pulse("eob_credit_used", in_valid && in_ready && in_word.eob, eob_credit_used);
         if (in_valid && in_word.sob && !sob_credit_avail) begin
            check_pulse("in_ready without credit", 1'b0, in_ready);
         end
         // a caught-up read index leaves at most two words past the buffer.
         if (sp_buf_idx == buf_idx_t'(n_received)) begin
            check_pulse("buf_full_stall with room in the buffer", 1'b0, buf_full_stall);
         end
         sob_pulses = sob_pulses + int'(sob_credit_used);
         eob_pulses = eob_pulses + int'(eob_credit_used);
         ready_run  = out_ready ? ready_run + 1 : 0;
         quiet_run  = buf_full_stall ? 0 : quiet_run + 1;
         if (in_valid && in_ready) begin
            record_accept();
         end
         if (out_valid && out_ready) begin
            take_output();
         end
      end
   end

   always @(posedge clk) begin
      cyc = cyc + 1;
      if (cyc > 40 * table_q.size() + 200) begin
         fail_now($sformatf("timeout after %0d cycles, %0d of %0d words received",
                            cyc, n_received, table_q.size()));
      end
   end

   initial begin : drive_consumer
      int       ph;
      logic     nxt_rdy;
      buf_idx_t nxt_sp;
      ph         = 0;
      out_ready  = 1'b0;
      sp_buf_idx = '0;
      forever begin
         @(posedge clk);
         nxt_rdy = rdy_pat[ph % 8];
         nxt_sp  = sp_follow ? buf_idx_t'(n_received) : sp_hold;
         ph++;
         #1;
         out_ready  = nxt_rdy;
         sp_buf_idx = nxt_sp;
      end
   end

   task automatic stall_phase();
      while (n_received < stall_words) @(negedge clk);
      repeat (4) begin
         @(negedge clk);
         check_pulse("buf_full_stall with the buffer full", 1'b1, buf_full_stall);
      end
      check_count("words past the full buffer", stall_words, n_received);
      check_bit_buf("bit_buf at stall", model_buf(stall_words), bit_buf);
      sp_follow = 1'b1;
      @(posedge clk);
      #1;
   endtask

   task automatic apply_entry(entry_t e);
      ld_meta_t m;
      if (e.wait_stall) begin
         stall_phase();
      end
      m         = '0;
      m.window  = e.window;
      m.numbits = e.numbits;
      m.sob     = e.sob;
      m.eob     = e.eob;
      in_word          = m;
      in_valid         = 1'b1;
      sob_credit_avail = e.credit;
      rdy_pat          = e.ready_pat;
      sp_follow        = e.sp_follow;
      sp_hold          = e.sp_buf_idx;
      if (e.sob && !e.credit) begin
         repeat (6) begin
            @(negedge clk);
            check_pulse("in_ready while waiting for credit", 1'b0, in_ready);
         end
         @(posedge clk);
         #1;
         sob_credit_avail = 1'b1;
      end
      @(negedge clk);
      while (!in_ready) @(negedge clk);
      @(posedge clk);
      #1;
   endtask

   initial begin
      in_valid         = 1'b0;
      in_word          = '0;
      sob_credit_avail = 1'b0;
      build_table();
      @(posedge rst_n);
      @(negedge clk);
      check_pulse("in_ready after reset", 1'b0, in_ready);
      check_pulse("out_valid after reset", 1'b0, out_valid);
      check_pulse("sob_credit_used after reset", 1'b0, sob_credit_used);
      check_pulse("eob_credit_used after reset", 1'b0, eob_credit_used);
      check_pulse("buf_full_stall after reset", 1'b0, buf_full_stall);
      @(posedge clk);
      #1;
      foreach (table_q[k]) begin
         apply_entry(table_q[k]);
      end
      in_valid  = 1'b0;
      rdy_pat   = 8'hff;
      sp_follow = 1'b1;
      while (n_received < table_q.size()) @(negedge clk);
      repeat (3) @(negedge clk);
      check_count("words accepted", table_q.size(), n_acc);
      check_count("words received", table_q.size(), n_received);
      check_count("sob_credit_used pulses", sob_words, sob_pulses);
      check_count("eob_credit_used pulses", eob_words, eob_pulses);
      check_bit_buf("bit_buf at end", model_buf(n_acc), bit_buf);
      $display("Test completed successfully");
      $finish;
   end

endmodule

// File: verif/ld_clk_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset generator.
// 10 ns clock, active-low reset held for a set number of cycles.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ld_clk_gen #(
   parameter int reset_cycles = 4
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // release just after an edge, in step with the stimulus.
   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule

// File: logic/ld_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lane pre-decoder top level.
// admit -> slice -> bit buffer -> slice -> lane decode -> slice.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ld_top #(
   parameter int buf_words = ld_pkg::buf_words
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             in_valid,
   input  ld_pkg::ld_meta_t in_word,
   output logic             in_ready,
   input  logic             sob_credit_avail,
   output logic             sob_credit_used,
   output logic             eob_credit_used,
   output logic             out_valid,
   input  logic             out_ready,
   output ld_pkg::ld_word_t out_word,
   input  ld_pkg::buf_idx_t sp_buf_idx,
   output ld_pkg::bit_buf_t bit_buf,
   output logic             buf_full_stall
);
   import ld_pkg::*;

   logic     adm_valid;
   logic     adm_ready;
   ld_word_t adm_word;
   logic     s1_valid;
   logic     s1_ready;
   ld_word_t s1_word;
   logic     bb_valid;
   logic     bb_ready;
   ld_word_t bb_word;
   logic     s2_valid;
   logic     s2_ready;
   ld_word_t s2_word;
   logic     dec_valid;
   logic     dec_ready;
   ld_word_t dec_word;

   ld_admit admit_i (
      .clk, .rst_n, .in_valid, .in_word, .in_ready,
      .sob_credit_avail, .sob_credit_used, .eob_credit_used,
      .adm_valid, .adm_ready, .adm_word
   );

   ld_pipe_slice slice1_i (
      .clk, .rst_n,
      .src_valid (adm_valid), .src_ready (adm_ready), .src_word (adm_word),
      .dst_valid (s1_valid),  .dst_ready (s1_ready),  .dst_word (s1_word)
   );

   ld_bit_buffer #(.buf_words(buf_words)) bit_buffer_i (
      .clk, .rst_n,
      .up_valid (s1_valid), .up_ready (s1_ready), .up_word (s1_word),
      .dn_valid (bb_valid), .dn_ready (bb_ready), .dn_word (bb_word),
      .sp_buf_idx, .bit_buf, .buf_full_stall
   );

   ld_pipe_slice slice2_i (
      .clk, .rst_n,
      .src_valid (bb_valid), .src_ready (bb_ready), .src_word (bb_word),
      .dst_valid (s2_valid), .dst_ready (s2_ready), .dst_word (s2_word)
   );

   ld_lane_decode #(.n_lanes(n_lanes)) lane_decode_i (
      .up_valid (s2_valid),  .up_ready (s2_ready),  .up_word (s2_word),
      .dn_valid (dec_valid), .dn_ready (dec_ready), .dn_word (dec_word)
   );

   ld_pipe_slice slice3_i (
      .clk, .rst_n,
      .src_valid (dec_valid), .src_ready (dec_ready), .src_word (dec_word),
      .dst_valid (out_valid), .dst_ready (out_ready), .dst_word (out_word)
   );

endmodule

// File: logic/ld_lane_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Parallel raw-block lane decode.
// Per lane: literal symbol, end mismatch check, end-of-block
// marking and end bit index.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ld_lane_decode #(
   parameter int n_lanes = ld_pkg::n_lanes
) (
   input  logic             up_valid,
   output logic             up_ready,
   input  ld_pkg::ld_word_t up_word,
   output logic             dn_valid,
   input  logic             dn_ready,
   output ld_pkg::ld_word_t dn_word
);
   import ld_pkg::*;

   // raw blocks carry fixed 8-bit literals.
   localparam int sym_len = 8;

   assign dn_valid = up_valid;
   assign up_ready = dn_ready;

   always_comb begin
      dn_word = up_word;
      for (int i = 0; i < n_lanes; i++) begin
         numbits_t lane_end;
         end_idx_t idx;
         ld_lane_t lane;

         lane_end    = numbits_t'(i + sym_len);
         lane        = '0;
         lane.symbol = up_word.meta.window[i +: sym_len];

         // symbol runs past the valid bits of this word.
         if (lane_end > up_word.meta.numbits) begin
            lane.error   = 1'b1;
            lane.errcode = end_mismatch;
         end else begin
            lane.error   = 1'b0;
            lane.errcode = none;
         end

         // the lane that ends exactly on the last bit closes the block.
         if (lane_end == up_word.meta.numbits) begin
            lane.eob = up_word.meta.eob;
         end
         lane.eob = lane.eob | lane.error;

         idx = end_idx_t'({up_word.meta.word_pos, 5'd0} + i + sym_len);

         // a block end moves the index up to the next word boundary.
         if (lane.eob && (idx[4:0] != 5'd0)) begin
            idx = {idx[7:5] + 3'd1, 5'd0};
         end
         lane.end_idx = idx;

         dn_word.lanes[i] = lane;
      end
   end

endmodule

// File: logic/ld_bit_buffer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Circular bit buffer stage.
// Writes each window at the write index, tags the word with that
// index, and stalls when the consumer's read index would be overrun.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ld_bit_buffer #(
   parameter int buf_words = ld_pkg::buf_words
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             up_valid,
   output logic             up_ready,
   input  ld_pkg::ld_word_t up_word,
   output logic             dn_valid,
   input  logic             dn_ready,
   output ld_pkg::ld_word_t dn_word,
   input  ld_pkg::buf_idx_t sp_buf_idx,
   output ld_pkg::bit_buf_t bit_buf,
   output logic             buf_full_stall
);
   import ld_pkg::*;

   localparam int idx_bits  = $clog2(buf_words);
   localparam int win_words = window_bits / 32;

   buf_idx_t wr_idx_q;
   buf_idx_t wr_idx_nxt;
   bit_buf_t buf_q;
   int       occupancy;
   logic     full;
   logic     xfer;

   // words between read and write index; the wrap bit counts as a lap.
   function automatic int idx_dist(buf_idx_t wr, buf_idx_t rd);
      int lin_wr;
      int lin_rd;
      lin_wr = int'(wr[idx_bits-1:0]) + (wr[idx_bits] ? buf_words : 0);
      lin_rd = int'(rd[idx_bits-1:0]) + (rd[idx_bits] ? buf_words : 0);
      if (lin_wr < lin_rd) begin
         lin_wr = lin_wr + 2 * buf_words;
      end
      return lin_wr - lin_rd;
   endfunction

   assign occupancy = idx_dist(wr_idx_q, sp_buf_idx);
   assign full      = (occupancy + win_words) > buf_words;

   assign dn_valid       = up_valid && !full;
   assign up_ready       = dn_ready && !full;
   assign xfer           = dn_valid && dn_ready;
   assign buf_full_stall = up_valid && full;
   assign bit_buf        = buf_q;

   always_comb begin
      dn_word              = up_word;
      dn_word.meta.buf_idx = wr_idx_q;
   end

   always_comb begin
      wr_idx_nxt = wr_idx_q + 1'b1;
      if (wr_idx_q[idx_bits-1:0] == idx_bits'(buf_words - 1)) begin
         wr_idx_nxt           = '0;
         wr_idx_nxt[idx_bits] = ~wr_idx_q[idx_bits];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_idx_q <= '0;
      end else if (xfer) begin
         wr_idx_q <= wr_idx_nxt;
      end
   end

   // whole window goes in, wrapping around the end of the buffer.
   always_ff @(posedge clk) begin
      if (xfer) begin
         for (int k = 0; k < win_words; k++) begin
            buf_q[(int'(wr_idx_q[idx_bits-1:0]) + k) % buf_words] <=
               up_word.meta.window[32*k +: 32];
         end
      end
   end

   a_occ_bound: assert property (@(posedge clk) disable iff (!rst_n)
      occupancy <= buf_words);

endmodule

// File: logic/ld_admit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input stage of the pre-decoder.
// Start-of-block credit gating, credit use pulses and the
// block position counter.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ld_admit (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             in_valid,
   input  ld_pkg::ld_meta_t in_word,
   output logic             in_ready,
   input  logic             sob_credit_avail,
   output logic             sob_credit_used,
   output logic             eob_credit_used,
   output logic             adm_valid,
   input  logic             adm_ready,
   output ld_pkg::ld_word_t adm_word
);
   import ld_pkg::*;

   word_pos_t pos_q;
   word_pos_t pos_tag;
   logic      accept;

   // a new block needs a credit before its first word may go.
   assign adm_valid = in_valid && (!in_word.sob || sob_credit_avail);
   assign accept    = adm_valid && adm_ready;
   assign in_ready  = accept;

   assign sob_credit_used = accept && in_word.sob;
   assign eob_credit_used = accept && in_word.eob;

   // first word of a block is always position 0.
   assign pos_tag = in_word.sob ? '0 : pos_q;

   always_comb begin
      adm_word               = '0;
      adm_word.meta          = in_word;
      adm_word.meta.word_pos = pos_tag;
      adm_word.meta.buf_idx  = '0;
   end

   // wraps at 8 by width.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pos_q <= '0;
      end else if (accept) begin
         pos_q <= word_pos_t'(pos_tag + 1'b1);
      end
   end

endmodule

// File: logic/ld_pipe_slice.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Forward-registered valid/ready slice for one pipeline word.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ld_pipe_slice (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             src_valid,
   output logic             src_ready,
   input  ld_pkg::ld_word_t src_word,
   output logic             dst_valid,
   input  logic             dst_ready,
   output ld_pkg::ld_word_t dst_word
);
   import ld_pkg::*;

   logic     full_q;
   ld_word_t word_q;

   // room when empty, or when the held word leaves this cycle.
   assign src_ready = !full_q || dst_ready;
   assign dst_valid = full_q;
   assign dst_word  = word_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         full_q <= 1'b0;
      end else if (src_ready) begin
         full_q <= src_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (src_valid && src_ready) begin
         word_q <= src_word;
      end
   end

   // a stalled word stays put until the next stage takes it.
   a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
      dst_valid && !dst_ready |=> dst_valid && $stable(dst_word));

endmodule

// File: logic/ld_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared sizes and types of the lane pre-decoder.
// Holds the window, index and lane types, the lane error codes,
// and the pipeline word that travels between the stages.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ld_pkg;

   // decode lanes per word, one per starting bit.
   localparam int n_lanes = 32;

   // lookahead window; the low 32 bits are the word itself.
   localparam int window_bits = 128;

   // 32-bit words held by the circular bit buffer.
   localparam int buf_words = 16;

   // word index plus one wrap bit.
   localparam int buf_idx_bits = $clog2(buf_words) + 1;

   typedef logic [window_bits-1:0]  window_t;
   typedef logic [7:0]              numbits_t;
   typedef logic [buf_idx_bits-1:0] buf_idx_t;

   // position of the word within its block, modulo 8.
   typedef logic [2:0]              word_pos_t;

   // end bit index inside a group of 8 words.
   typedef logic [7:0]              end_idx_t;

   typedef logic [7:0]              symbol_t;

   typedef enum logic [0:0] {
      none         = 1'b0,
      end_mismatch = 1'b1
   } ld_err_e;

   // per-word information carried down the pipe.
   typedef struct packed {
      window_t   window;
      numbits_t  numbits;
      logic      sob;
      logic      eob;
      word_pos_t word_pos;
      buf_idx_t  buf_idx;
   } ld_meta_t;

   // result of one decode lane.
   typedef struct packed {
      symbol_t  symbol;
      logic     error;
      ld_err_e  errcode;
      logic     eob;
      end_idx_t end_idx;
   } ld_lane_t;

   // one pipeline word: meta plus every lane.
   typedef struct packed {
      ld_meta_t                 meta;
      ld_lane_t [n_lanes-1:0]   lanes;
   } ld_word_t;

   // the whole bit buffer as the consumer sees it.
   typedef logic [buf_words-1:0][31:0] bit_buf_t;

endpackage
